// File: hw/stats_pkg.sv
// Statistics path package with widths, counter types and APB request/response structs
package stats_pkg;

    // Increment sources, one per Ethernet quad
    localparam int STAT_PORTS = 2;
    localparam int STAT_PORT_W = (STAT_PORTS > 1) ? $clog2(STAT_PORTS) : 1;

    // Counter id, increment amount and accumulated total
    localparam int STAT_ID_W = 5;
    localparam int STAT_INC_W = 16;
    localparam int STAT_COUNT_W = 64;
    localparam int STAT_COUNTERS = 2 ** STAT_ID_W;

    // Host register port
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    typedef logic [STAT_PORT_W-1:0] stat_port_t;
    typedef logic [STAT_ID_W-1:0] stat_id_t;
    typedef logic [STAT_INC_W-1:0] stat_inc_t;
    typedef logic [STAT_COUNT_W-1:0] stat_count_t;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;

    // One tagged increment of 22 bits
    typedef struct packed {
        logic valid;
        stat_id_t id;
        stat_inc_t inc;
    } stat_req_t;

    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        logic pready;
        apb_data_t prdata;
        logic pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_READ,
        APB_DONE
    } apb_state_t;

endpackage

// File: hw/stat_arb_mux.sv
// Round-robin merge of per-port increment streams into one registered stream
`timescale 1ns/1ps

module stat_arb_mux (
    input  logic                  clk_125mhz,
    input  logic                  rst_n_i,
    input  stats_pkg::stat_req_t  req_i [stats_pkg::STAT_PORTS],
    output logic [stats_pkg::STAT_PORTS-1:0] ready_o,
    output stats_pkg::stat_req_t  req_o,
    input  logic                  ready_i
);

    logic                  en_q;
    logic                  accept;
    logic                  grant_vld;
    stats_pkg::stat_port_t grant_idx;
    stats_pkg::stat_port_t prio_q;

    // Registered output request
    logic                  vld_q;
    stats_pkg::stat_id_t   id_q;
    stats_pkg::stat_inc_t  inc_q;

    // Output slot free or being drained this cycle
    assign accept = en_q && (!vld_q || ready_i);

    // Walk ports from the priority pointer; ready reaches every port
    // up to and including the first one that requests
    always_comb begin
        int idx;
        grant_vld = 1'b0;
        grant_idx = prio_q;
        ready_o = '0;
        for (int i = 0; i < stats_pkg::STAT_PORTS; i++) begin
            idx = (int'(prio_q) + i) % stats_pkg::STAT_PORTS;
            if (!grant_vld) begin
                ready_o[idx] = accept;
                if (req_i[idx].valid) begin
                    grant_vld = 1'b1;
                    grant_idx = stats_pkg::stat_port_t'(idx);
                end
            end
        end
    end

    always_ff @(posedge clk_125mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q <= 1'b0;
            vld_q <= 1'b0;
            prio_q <= '0;
        end else begin
            en_q <= 1'b1;
            if (accept) begin
                vld_q <= grant_vld;
            end
            if (accept && grant_vld) begin
                // Port after the winner gets top priority next
                if (int'(grant_idx) == stats_pkg::STAT_PORTS - 1) begin
                    prio_q <= '0;
                end else begin
                    prio_q <= grant_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (accept && grant_vld) begin
            id_q <= req_i[grant_idx].id;
            inc_q <= req_i[grant_idx].inc;
        end
    end

    assign req_o = '{valid: vld_q, id: id_q, inc: inc_q};

endmodule

// File: hw/stat_counter_bank.sv
// Two-stage read-add-write bank of 64-bit statistics counters with a host read port
`timescale 1ns/1ps

module stat_counter_bank (
    input  logic                   clk_125mhz,
    input  logic                   rst_n_i,
    input  stats_pkg::stat_req_t   req_i,
    output logic                   ready_o,
    input  logic                   rd_en_i,
    input  stats_pkg::stat_id_t    rd_id_i,
    output stats_pkg::stat_count_t rd_data_o
);

    stats_pkg::stat_count_t cnt_q [stats_pkg::STAT_COUNTERS];

    logic                   en_q;
    logic                   accept;

    // Stage 1 holds the accepted increment while the counter is read
    logic                   s1_vld_q;
    stats_pkg::stat_id_t    s1_id_q;
    stats_pkg::stat_inc_t   s1_inc_q;
    stats_pkg::stat_count_t s1_base;
    stats_pkg::stat_count_t s1_sum;

    // Stage 2 holds the new total until it is written back
    logic                   s2_vld_q;
    stats_pkg::stat_id_t    s2_id_q;
    stats_pkg::stat_count_t s2_sum_q;

    stats_pkg::stat_count_t rd_data_q;

    // Host read steals the cycle from the increment path
    assign ready_o = en_q && !rd_en_i;
    assign accept = req_i.valid && ready_o;

    // Stage 2 not yet written, so take its sum for a matching id
    always_comb begin
        if (s2_vld_q && (s2_id_q == s1_id_q)) begin
            s1_base = s2_sum_q;
        end else begin
            s1_base = cnt_q[s1_id_q];
        end
        s1_sum = s1_base + stats_pkg::stat_count_t'(s1_inc_q);
    end

    always_ff @(posedge clk_125mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q <= 1'b0;
            s1_vld_q <= 1'b0;
            s2_vld_q <= 1'b0;
        end else begin
            en_q <= 1'b1;
            s1_vld_q <= accept;
            s2_vld_q <= s1_vld_q;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (accept) begin
            s1_id_q <= req_i.id;
            s1_inc_q <= req_i.inc;
        end
        if (s1_vld_q) begin
            s2_id_q <= s1_id_q;
            s2_sum_q <= s1_sum;
        end
    end

    // Counter array written back from stage 2
    always_ff @(posedge clk_125mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < stats_pkg::STAT_COUNTERS; i++) begin
                cnt_q[i] <= '0;
            end
        end else if (s2_vld_q) begin
            cnt_q[s2_id_q] <= s2_sum_q;
        end
    end

    // Read data one cycle after rd_en with the pending write-back included
    always_ff @(posedge clk_125mhz) begin
        if (rd_en_i) begin
            if (s2_vld_q && (s2_id_q == rd_id_i)) begin
                rd_data_q <= s2_sum_q;
            end else begin
                rd_data_q <= cnt_q[rd_id_i];
            end
        end
    end

    assign rd_data_o = rd_data_q;

endmodule

// File: hw/stat_apb_regs.sv
// APB slave that maps host reads onto counter-bank reads and returns 32-bit halves
`timescale 1ns/1ps

module stat_apb_regs (
    input  logic                   clk_125mhz,
    input  logic                   rst_n_i,
    input  stats_pkg::apb_req_t    apb_req_i,
    output stats_pkg::apb_rsp_t    apb_rsp_o,
    output logic                   rd_en_o,
    output stats_pkg::stat_id_t    rd_id_o,
    input  stats_pkg::stat_count_t rd_data_i
);

    stats_pkg::apb_state_t state_q;
    stats_pkg::stat_id_t   id_q;
    logic                  half_q;
    logic                  wr_q;
    logic                  setup;

    // Setup phase seen while idle
    assign setup = apb_req_i.psel && !apb_req_i.penable;

    always_ff @(posedge clk_125mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= stats_pkg::APB_IDLE;
            wr_q <= 1'b0;
        end else begin
            case (state_q)
                stats_pkg::APB_IDLE: begin
                    if (setup) begin
                        wr_q <= apb_req_i.pwrite;
                        // Writes skip the bank and finish next cycle
                        state_q <= apb_req_i.pwrite ? stats_pkg::APB_DONE
                                                    : stats_pkg::APB_READ;
                    end
                end
                stats_pkg::APB_READ: state_q <= stats_pkg::APB_DONE;
                default: state_q <= stats_pkg::APB_IDLE;
            endcase
        end
    end

    // Word address is id * 2 + half
    always_ff @(posedge clk_125mhz) begin
        if (state_q == stats_pkg::APB_IDLE && setup) begin
            id_q <= apb_req_i.paddr[3 +: stats_pkg::STAT_ID_W];
            half_q <= apb_req_i.paddr[2];
        end
    end

    assign rd_en_o = (state_q == stats_pkg::APB_READ);
    assign rd_id_o = id_q;

    always_comb begin
        apb_rsp_o.pready = (state_q == stats_pkg::APB_DONE);
        apb_rsp_o.pslverr = (state_q == stats_pkg::APB_DONE) && wr_q;
        apb_rsp_o.prdata = '0;
        if (state_q == stats_pkg::APB_DONE && !wr_q) begin
            apb_rsp_o.prdata = half_q ? rd_data_i[stats_pkg::APB_DATA_W +: stats_pkg::APB_DATA_W]
                                      : rd_data_i[0 +: stats_pkg::APB_DATA_W];
        end
    end

endmodule

// File: hw/stats_core.sv
// Statistics core joining the increment arbiter, counter bank and APB registers
`timescale 1ns/1ps

module stats_core (
    input  logic                  clk_125mhz,
    input  logic                  rst_n_i,
    input  stats_pkg::stat_req_t  stat_req_i [stats_pkg::STAT_PORTS],
    output logic [stats_pkg::STAT_PORTS-1:0] stat_ready_o,
    input  stats_pkg::apb_req_t   apb_req_i,
    output stats_pkg::apb_rsp_t   apb_rsp_o
);

    // Merged increment stream
    stats_pkg::stat_req_t   arb_req;
    logic                   bank_ready;

    // Host read path
    logic                   rd_en;
    stats_pkg::stat_id_t    rd_id;
    stats_pkg::stat_count_t rd_data;

    stat_arb_mux u_stat_arb_mux (
        .clk_125mhz (clk_125mhz),
        .rst_n_i    (rst_n_i),
        .req_i      (stat_req_i),
        .ready_o    (stat_ready_o),
        .req_o      (arb_req),
        .ready_i    (bank_ready)
    );

    stat_counter_bank u_stat_counter_bank (
        .clk_125mhz (clk_125mhz),
        .rst_n_i    (rst_n_i),
        .req_i      (arb_req),
        .ready_o    (bank_ready),
        .rd_en_i    (rd_en),
        .rd_id_i    (rd_id),
        .rd_data_o  (rd_data)
    );

    stat_apb_regs u_stat_apb_regs (
        .clk_125mhz (clk_125mhz),
        .rst_n_i    (rst_n_i),
        .apb_req_i  (apb_req_i),
        .apb_rsp_o  (apb_rsp_o),
        .rd_en_o    (rd_en),
        .rd_id_o    (rd_id),
        .rd_data_i  (rd_data)
    );

endmodule

// File: dv/stats_core_assertions.sv
// Concurrent handshake checks bound into the statistics core
`timescale 1ns/1ps

module stats_core_assertions (
    input logic                             clk_125mhz,
    input logic                             rst_n_i,
    input stats_pkg::stat_req_t             stat_req_i [stats_pkg::STAT_PORTS],
    input logic [stats_pkg::STAT_PORTS-1:0] stat_ready_o,
    input stats_pkg::apb_req_t              apb_req_i,
    input stats_pkg::apb_rsp_t              apb_rsp_o
);

    // A raised request waits for its transfer
    for (genvar p = 0; p < stats_pkg::STAT_PORTS; p++) begin : g_port
        valid_held: assert property (@(posedge clk_125mhz) disable iff (!rst_n_i)
            stat_req_i[p].valid && !stat_ready_o[p] |=> stat_req_i[p].valid)
            else $error("port %0d dropped valid before ready", p);
    end

    // One pready cycle ends each transfer
    pready_single: assert property (@(posedge clk_125mhz) disable iff (!rst_n_i)
        apb_rsp_o.pready |=> !apb_rsp_o.pready)
        else $error("pready high for more than one cycle");

    pready_in_access: assert property (@(posedge clk_125mhz) disable iff (!rst_n_i)
        apb_rsp_o.pready |-> apb_req_i.psel && apb_req_i.penable)
        else $error("pready outside an access phase");

    pslverr_with_pready: assert property (@(posedge clk_125mhz) disable iff (!rst_n_i)
        apb_rsp_o.pslverr |-> apb_rsp_o.pready)
        else $error("pslverr without pready");

endmodule

bind stats_core stats_core_assertions u_stats_core_assertions (.*);

// File: dv/tb_stats_core.sv
// Testbench for the statistics core, running the case file against a counter model
`timescale 1ns/1ps

module tb_stats_core;

    localparam int NP = stats_pkg::STAT_PORTS;
    localparam int DRAIN_CYCLES = 4;
    localparam int HS_LIMIT = 64;
    localparam int CASE_CYCLES = 200;

    logic                 clk_125mhz;
    logic                 rst_n;
    stats_pkg::stat_req_t stat_req [NP];
    logic [NP-1:0]        stat_ready;
    stats_pkg::apb_req_t  apb_req;
    stats_pkg::apb_rsp_t  apb_rsp;

    // Counter model and parsed case lines
    stats_pkg::stat_count_t model [stats_pkg::STAT_COUNTERS];
    string                  op_q [$];
    logic [3:0][31:0]       arg_q [$];
    int                     errors = 0;
    int                     checks = 0;
    int                     tests = 0;
    int                     failed_tests = 0;
    int unsigned            budget = 0;
    bit                     armed = 1'b0;

    stats_core u_stats_core (
        .clk_125mhz   (clk_125mhz),
        .rst_n_i      (rst_n),
        .stat_req_i   (stat_req),
        .stat_ready_o (stat_ready),
        .apb_req_i    (apb_req),
        .apb_rsp_o    (apb_rsp)
    );

    initial begin
        clk_125mhz = 1'b0;
        forever #5 clk_125mhz = ~clk_125mhz;
    end

    // Budget grows with the case count and the burst lengths
    initial begin
        wait (armed);
        repeat (budget) @(posedge clk_125mhz);
        $display("Watchdog expired after %0d cycles", budget);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("Error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_125mhz);
        #1;
    endtask

    // Each port keeps its request up until it has transferred count times
    task automatic send_incs(input stats_pkg::stat_id_t ids [NP],
                             input stats_pkg::stat_inc_t incs [NP],
                             input int unsigned count [NP]);
        int unsigned   left [NP];
        logic [NP-1:0] fire;
        int            stall;
        bit            busy;
        left = count;
        stall = 0;
        busy = 1'b1;
        while (busy && stall < HS_LIMIT) begin
            for (int p = 0; p < NP; p++) begin
                stat_req[p] = '{valid: left[p] != 0, id: ids[p], inc: incs[p]};
            end
            @(negedge clk_125mhz);
            for (int p = 0; p < NP; p++) begin
                fire[p] = stat_req[p].valid && stat_ready[p];
            end
            next_cycle();
            stall = (fire == '0) ? stall + 1 : 0;
            busy = 1'b0;
            for (int p = 0; p < NP; p++) begin
                if (fire[p]) begin
                    model[ids[p]] = model[ids[p]] + stats_pkg::stat_count_t'(incs[p]);
                    left[p]--;
                end
                busy |= (left[p] != 0);
            end
        end
        for (int p = 0; p < NP; p++) begin
            stat_req[p] = '0;
        end
        check_true(!busy, "increment request was never accepted");
    endtask

    // Setup then access phase while counting access cycles before pready
    task automatic apb_xfer(input logic wr, input stats_pkg::apb_addr_t addr,
                            output stats_pkg::apb_data_t rdata, output logic slverr,
                            output int waits);
        bit seen;
        seen = 1'b0;
        waits = 0;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr,
                    pwdata: {24'h5a5a5a, addr}};
        next_cycle();
        apb_req.penable = 1'b1;
        while (!seen && waits < HS_LIMIT) begin
            @(negedge clk_125mhz);
            seen = apb_rsp.pready;
            rdata = apb_rsp.prdata;
            slverr = apb_rsp.pslverr;
            next_cycle();
            if (!seen) waits++;
        end
        apb_req = '0;
        check_true(seen, "APB transfer never saw pready");
    endtask

    // Four bytes per word, and the word address is id * 2 + half
    task automatic read_word(input stats_pkg::apb_addr_t addr, input logic [31:0] exp);
        stats_pkg::apb_data_t   rdata;
        stats_pkg::stat_count_t cnt;
        logic [31:0]            half_val;
        logic                   slverr;
        int                     waits;
        int                     word;
        repeat (DRAIN_CYCLES) next_cycle();
        apb_xfer(1'b0, addr, rdata, slverr, waits);
        word = int'(addr) / 4;
        cnt = model[word / 2];
        half_val = (word % 2 == 1) ? cnt[63:32] : cnt[31:0];
        check_value("prdata (model)", 64'(rdata), 64'(half_val));
        check_value("prdata (expected)", 64'(rdata), 64'(exp));
        check_value("pslverr", 64'(slverr), 64'(0));
        check_value("read wait states", 64'(waits), 64'(1));
    endtask

    task automatic close_test(input string name, input int err_before);
        tests++;
        if (errors != err_before) failed_tests++;
        $display("%-24s %s", name, (errors == err_before) ? "passed" : "failed");
    endtask

    task automatic run_case(input int idx);
        string                  op;
        logic [3:0][31:0]       a;
        stats_pkg::stat_id_t    ids [NP];
        stats_pkg::stat_inc_t   incs [NP];
        int unsigned            cnt [NP];
        stats_pkg::apb_data_t   rdata;
        logic                   slverr;
        int                     waits;
        int                     port;
        int                     err_before;
        op = op_q[idx];
        a = arg_q[idx];
        err_before = errors;
        ids = '{default: '0};
        incs = '{default: '0};
        cnt = '{default: 0};
        port = int'(a[0]);
        if (op == "inc" || op == "burst") begin
            check_true(port < NP, "port number out of range");
            ids[port] = stats_pkg::stat_id_t'(a[1]);
            incs[port] = stats_pkg::stat_inc_t'(a[2]);
            cnt[port] = (op == "inc") ? 1 : a[3];
            send_incs(ids, incs, cnt);
        end else if (op == "par") begin
            ids = '{stats_pkg::stat_id_t'(a[0]), stats_pkg::stat_id_t'(a[2])};
            incs = '{stats_pkg::stat_inc_t'(a[1]), stats_pkg::stat_inc_t'(a[3])};
            cnt = '{1, 1};
            send_incs(ids, incs, cnt);
        end else if (op == "rd") begin
            read_word(stats_pkg::apb_addr_t'(a[0]), a[1]);
        end else if (op == "wr") begin
            apb_xfer(1'b1, stats_pkg::apb_addr_t'(a[0]), rdata, slverr, waits);
            check_value("pslverr", 64'(slverr), 64'(1));
            check_value("write wait states", 64'(waits), 64'(0));
        end else if (op == "idle") begin
            repeat (a[0]) next_cycle();
        end else begin
            check_true(1'b0, {"unknown operation in case file: ", op});
        end
        close_test($sformatf("case %0d %s", idx + 1, op), err_before);
    endtask

    initial begin
        int          fd;
        string       line;
        string       op;
        logic [31:0] v [4];
        int          err_before;
        rst_n = 1'b0;
        apb_req = '0;
        for (int p = 0; p < NP; p++) stat_req[p] = '0;
        for (int i = 0; i < stats_pkg::STAT_COUNTERS; i++) model[i] = '0;
        fd = $fopen("dv/stats_cases.txt", "r");
        check_true(fd != 0, "cannot open dv/stats_cases.txt");
        while (fd != 0 && $fgets(line, fd) > 0) begin
            v = '{default: '0};
            if ($sscanf(line, "%s", op) == 1 && op.substr(0, 0) != "#") begin
                if (op == "rd" || op == "wr") begin
                    void'($sscanf(line, "%s %h %h", op, v[0], v[1]));
                end else begin
                    void'($sscanf(line, "%s %d %d %d %d", op, v[0], v[1], v[2], v[3]));
                end
                op_q.push_back(op);
                arg_q.push_back({v[3], v[2], v[1], v[0]});
                budget += CASE_CYCLES + ((op == "burst") ? v[3] : 0);
            end
        end
        if (fd != 0) $fclose(fd);
        // Reset sweep reads every word
        budget += 2 * stats_pkg::STAT_COUNTERS * (DRAIN_CYCLES + 8) + CASE_CYCLES;
        armed = 1'b1;
        repeat (2) @(posedge clk_125mhz);
        #1;
        rst_n = 1'b1;

        // Ready is low for the first cycle out of reset, then high
        err_before = errors;
        @(negedge clk_125mhz);
        check_value("stat_ready_o", 64'(stat_ready), 64'(0));
        check_value("pready", 64'(apb_rsp.pready), 64'(0));
        @(negedge clk_125mhz);
        check_value("stat_ready_o", 64'(stat_ready), 64'({NP{1'b1}}));
        next_cycle();
        for (int i = 0; i < 2 * stats_pkg::STAT_COUNTERS; i++) begin
            read_word(stats_pkg::apb_addr_t'(i * 4), '0);
        end
        close_test("reset", err_before);

        for (int i = 0; i < op_q.size(); i++) run_case(i);
        $display("Tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 tests, tests - failed_tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: dv/stats_cases.txt
# inc port id amount | par id amount id amount | burst port id amount count | idle cycles
# rd byte_addr_hex expected_hex | wr byte_addr_hex; ids, amounts and counts in decimal
inc 0 3 42
idle 3
rd 18 0000002a
rd 1c 00000000
inc 1 5 7
rd 28 00000007
par 7 100 7 200
par 9 5 10 6
rd 38 0000012c
rd 48 00000005
rd 50 00000006
burst 1 12 1000 50
rd 60 0000c350
burst 0 31 65535 65538
rd f8 0000fffe
rd fc 00000001
wr 18
rd 18 0000002a

// File: vlog.f
hw/stats_pkg.sv
hw/stat_arb_mux.sv
hw/stat_counter_bank.sv
hw/stat_apb_regs.sv
hw/stats_core.sv
dv/stats_core_assertions.sv
dv/tb_stats_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       ?= tb_stats_core
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= TEST FAILED
PASS_MSG  ?= TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a verdict"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
